//--- all.f
hdl/npu_cfg_pkg.sv
hdl/npu_op_pkg.sv
hdl/npu_ctrl.sv
hdl/stream_loader.sv
hdl/sram_banks.sv
hdl/elementwise_alu.sv
hdl/stream_writer.sv
hdl/npu_top.sv
test/tb_npu.sv

//--- hdl/elementwise_alu.sv
`timescale 1ns/10ps
// one-stage 8-lane int8 ALU; ADD, SUB and shifted MUL, each saturated to int8
module elementwise_alu (
    input  logic                            s00_axis_aclk,
    input  logic                            s00_axis_aresetn,
    input  logic                            valid_i,
    input  logic [npu_cfg_pkg::ADDR_W-1:0]  addr_i,
    input  npu_op_pkg::lane_word_u          a_i,
    input  npu_op_pkg::lane_word_u          b_i,
    input  npu_op_pkg::op_e                 op_i,
    input  logic [npu_op_pkg::SHIFT_W-1:0]  mul_shift_i,
    output logic                            valid_o,
    output logic [npu_cfg_pkg::ADDR_W-1:0]  addr_o,
    output npu_op_pkg::lane_word_u          data_o
);
    import npu_cfg_pkg::*;
    import npu_op_pkg::*;

    // holds the full int8 x int8 product
    typedef logic signed [2*LANE_W-1:0] wide_t;

    lane_word_u res_d;

    function automatic lane_t sat_lane(input wide_t v);
        if (v > 127)
            return 8'sh7f;
        else if (v < -128)
            return 8'sh80;
        else
            return v[LANE_W-1:0];
    endfunction

    always_comb begin
        // unknown opcodes give zero
        res_d.raw = '0;
        for (int i = 0; i < LANES; i++) begin
            case (op_i)
                ADD_OP: res_d.lane[i] = sat_lane(wide_t'(a_i.lane[i]) + wide_t'(b_i.lane[i]));
                SUB_OP: res_d.lane[i] = sat_lane(wide_t'(a_i.lane[i]) - wide_t'(b_i.lane[i]));
                MUL_OP: begin
                    // arithmetic shift keeps the sign of the product
                    res_d.lane[i] = sat_lane(
                        (wide_t'(a_i.lane[i]) * wide_t'(b_i.lane[i])) >>> mul_shift_i);
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge s00_axis_aclk or negedge s00_axis_aresetn) begin
        if (!s00_axis_aresetn)
            valid_o <= 1'b0;
        else
            valid_o <= valid_i;
    end

    always_ff @(posedge s00_axis_aclk) begin
        addr_o <= addr_i;
        data_o <= res_d;
    end

endmodule

//--- hdl/npu_cfg_pkg.sv
// stream, lane, bank and address sizes; imported by every RTL unit of the NPU
package npu_cfg_pkg;

    // stream and SRAM word
    localparam int DATA_W = 64;
    localparam int LANE_W = 8;
    localparam int LANES  = DATA_W / LANE_W;

    // bank addressing
    localparam int ADDR_W    = 8;
    localparam int WORDS     = 1 << ADDR_W;
    localparam int NUM_BANKS = 3;
    localparam int BANK_W    = 2;

    // tuser carries the bank in the upper bits and the word address below
    localparam int USER_W  = BANK_W + ADDR_W;
    localparam int COUNT_W = ADDR_W + 1;

    // fixed bank roles for the two operands and the result
    localparam logic [BANK_W-1:0] BANK_A = 2'd0;
    localparam logic [BANK_W-1:0] BANK_B = 2'd1;
    localparam logic [BANK_W-1:0] BANK_C = 2'd2;

endpackage

//--- hdl/npu_ctrl.sv
`timescale 1ns/10ps
// control FSM that gates loading, issues operand reads, counts results and starts output
module npu_ctrl (
    input  logic                            s00_axis_aclk,
    input  logic                            s00_axis_aresetn,
    input  npu_op_pkg::op_e                 op_i,
    input  logic [npu_op_pkg::SHIFT_W-1:0]  mul_shift_i,
    input  logic [npu_cfg_pkg::COUNT_W-1:0] op_words_i,
    input  logic                            metadata_valid_i,
    input  logic                            metadata_done_i,
    input  logic                            finish_calc_i,
    input  logic                            res_valid_i,
    input  logic                            out_done_i,
    output logic                            load_en_o,
    output logic                            rd_en_o,
    output logic [npu_cfg_pkg::ADDR_W-1:0]  rd_addr_o,
    output npu_op_pkg::op_e                 op_o,
    output logic [npu_op_pkg::SHIFT_W-1:0]  mul_shift_o,
    output logic                            out_start_o,
    output logic                            layer_done_o
);
    import npu_cfg_pkg::*;
    import npu_op_pkg::*;

    state_e             state_q;
    state_e             state_d;
    logic [COUNT_W-1:0] words_q;
    logic [COUNT_W-1:0] iss_cnt_q;
    logic [COUNT_W-1:0] res_cnt_q;
    logic [COUNT_W-1:0] res_next;

    // input stream only open while waiting for operands
    assign load_en_o = (state_q == WAIT_META);
    assign rd_en_o   = (state_q == WAIT_OP) && (iss_cnt_q < words_q);
    assign rd_addr_o = iss_cnt_q[ADDR_W-1:0];
    assign res_next  = res_cnt_q + COUNT_W'(res_valid_i);

    // ------------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (metadata_valid_i)
                    state_d = WAIT_META;
            end
            WAIT_META: begin
                if (metadata_done_i)
                    state_d = WAIT_OP;
                else if (finish_calc_i)
                    state_d = WRITE_OUTPUT;
            end
            WAIT_OP: begin
                // leave once the last result lands in bank C
                if (res_next >= words_q)
                    state_d = OP_DONE;
            end
            OP_DONE:      state_d = WAIT_META;
            WRITE_OUTPUT: begin
                if (out_done_i)
                    state_d = IDLE;
            end
            default:      state_d = IDLE;
        endcase
    end

    always_ff @(posedge s00_axis_aclk or negedge s00_axis_aresetn) begin
        if (!s00_axis_aresetn) begin
            state_q      <= IDLE;
            iss_cnt_q    <= '0;
            res_cnt_q    <= '0;
            out_start_o  <= 1'b0;
            layer_done_o <= 1'b0;
        end else begin
            state_q      <= state_d;
            out_start_o  <= (state_d == WRITE_OUTPUT) && (state_q != WRITE_OUTPUT);
            layer_done_o <= (state_q == OP_DONE);
            if (state_q == OP_DONE) begin
                iss_cnt_q <= '0;
                res_cnt_q <= '0;
            end else if (state_q == WAIT_OP) begin
                if (rd_en_o)
                    iss_cnt_q <= iss_cnt_q + COUNT_W'(1);
                res_cnt_q <= res_next;
            end
        end
    end

    // operation is held for the whole of WAIT_OP
    always_ff @(posedge s00_axis_aclk) begin
        if (state_q == WAIT_META && metadata_done_i) begin
            op_o        <= op_i;
            mul_shift_o <= mul_shift_i;
            words_q     <= op_words_i;
        end
    end

    a_op_legal: assert property (@(posedge s00_axis_aclk) disable iff (!s00_axis_aresetn)
        state_q == WAIT_OP |-> op_o inside {ADD_OP, SUB_OP, MUL_OP});

    a_done_pulse: assert property (@(posedge s00_axis_aclk) disable iff (!s00_axis_aresetn)
        layer_done_o |=> !layer_done_o);

endmodule

//--- hdl/npu_op_pkg.sv
// opcode and FSM state encodings plus the lane-word view; used by control, ALU and top
package npu_op_pkg;

    // right shift applied to the MUL product
    localparam int SHIFT_W = 3;

    // opcode values of the element-wise operations
    typedef enum logic [3:0] {
        IDLE_OP = 4'd0,
        ADD_OP  = 4'd5,
        SUB_OP  = 4'd6,
        MUL_OP  = 4'd7
    } op_e;

    typedef enum logic [2:0] {
        IDLE         = 3'd0,
        WAIT_META    = 3'd1,
        WAIT_OP      = 3'd2,
        OP_DONE      = 3'd3,
        WRITE_OUTPUT = 3'd4
    } state_e;

    typedef logic signed [npu_cfg_pkg::LANE_W-1:0] lane_t;

    // one word read raw on the stream side or as int8 lanes in the ALU
    // lane 0 sits in the low byte
    typedef union packed {
        logic [npu_cfg_pkg::DATA_W-1:0]  raw;
        lane_t [npu_cfg_pkg::LANES-1:0] lane;
    } lane_word_u;

endpackage

//--- hdl/npu_top.sv
`timescale 1ns/10ps
// element-wise NPU top level; stream in operands, run ADD/SUB/MUL, stream out bank C
module npu_top (
    input  logic                            s00_axis_aclk,
    input  logic                            s00_axis_aresetn,
    input  logic [npu_cfg_pkg::DATA_W-1:0]  s00_axis_tdata_i,
    input  logic                            s00_axis_tvalid_i,
    input  logic [npu_cfg_pkg::USER_W-1:0]  s00_axis_tuser_i,
    output logic                            s00_axis_tready_o,
    output logic [npu_cfg_pkg::DATA_W-1:0]  m00_axis_tdata_o,
    output logic                            m00_axis_tvalid_o,
    output logic                            m00_axis_tlast_o,
    input  logic                            m00_axis_tready_i,
    input  npu_op_pkg::op_e                 op_i,
    input  logic [npu_op_pkg::SHIFT_W-1:0]  mul_shift_i,
    input  logic [npu_cfg_pkg::COUNT_W-1:0] op_words_i,
    input  logic [npu_cfg_pkg::COUNT_W-1:0] out_words_i,
    input  logic                            metadata_valid_i,
    input  logic                            metadata_done_i,
    input  logic                            finish_calc_i,
    output logic                            layer_done_o
);
    import npu_cfg_pkg::*;
    import npu_op_pkg::*;

    // ------------------------------------------------------------------------
    // control and load path
    // ------------------------------------------------------------------------
    logic               load_en;
    logic               rd_en;
    logic [ADDR_W-1:0]  rd_addr;
    op_e                op_q;
    logic [SHIFT_W-1:0] shift_q;
    logic               out_start;
    logic               out_done;
    logic               wr_en;
    logic [BANK_W-1:0]  wr_bank;
    logic [ADDR_W-1:0]  wr_addr;
    logic [DATA_W-1:0]  wr_data;

    // operand, result and output words
    logic [DATA_W-1:0]  a_data;
    logic [DATA_W-1:0]  b_data;
    logic               rd_valid;
    logic [ADDR_W-1:0]  alu_addr;
    logic               res_valid;
    logic [ADDR_W-1:0]  res_addr;
    logic [DATA_W-1:0]  res_data;
    logic               out_rd_en;
    logic [ADDR_W-1:0]  out_rd_addr;
    logic [DATA_W-1:0]  out_data;

    npu_ctrl u_ctrl (
        .s00_axis_aclk, .s00_axis_aresetn,
        .op_i, .mul_shift_i, .op_words_i,
        .metadata_valid_i, .metadata_done_i, .finish_calc_i,
        .res_valid_i(res_valid), .out_done_i(out_done),
        .load_en_o(load_en), .rd_en_o(rd_en), .rd_addr_o(rd_addr),
        .op_o(op_q), .mul_shift_o(shift_q),
        .out_start_o(out_start), .layer_done_o
    );

    stream_loader u_loader (
        .s00_axis_aclk, .s00_axis_aresetn, .load_en_i(load_en),
        .tdata_i(s00_axis_tdata_i), .tvalid_i(s00_axis_tvalid_i), .tuser_i(s00_axis_tuser_i),
        .tready_o(s00_axis_tready_o), .wr_en_o(wr_en), .wr_bank_o(wr_bank),
        .wr_addr_o(wr_addr), .wr_data_o(wr_data)
    );

    sram_banks u_banks (
        .s00_axis_aclk, .s00_axis_aresetn,
        .wr_en_i(wr_en), .wr_bank_i(wr_bank), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
        .rd_en_i(rd_en), .rd_addr_i(rd_addr),
        .res_valid_i(res_valid), .res_addr_i(res_addr), .res_data_i(res_data),
        .out_rd_en_i(out_rd_en), .out_rd_addr_i(out_rd_addr),
        .a_data_o(a_data), .b_data_o(b_data), .rd_valid_o(rd_valid),
        .rd_addr_o(alu_addr), .out_data_o(out_data)
    );

    elementwise_alu u_alu (
        .s00_axis_aclk, .s00_axis_aresetn,
        .valid_i(rd_valid), .addr_i(alu_addr), .a_i(a_data), .b_i(b_data),
        .op_i(op_q), .mul_shift_i(shift_q),
        .valid_o(res_valid), .addr_o(res_addr), .data_o(res_data)
    );

    stream_writer u_writer (
        .s00_axis_aclk, .s00_axis_aresetn,
        .out_start_i(out_start), .out_words_i, .tready_i(m00_axis_tready_i),
        .out_data_i(out_data), .out_rd_en_o(out_rd_en), .out_rd_addr_o(out_rd_addr),
        .tdata_o(m00_axis_tdata_o), .tvalid_o(m00_axis_tvalid_o),
        .tlast_o(m00_axis_tlast_o), .out_done_o(out_done)
    );

endmodule

//--- hdl/sram_banks.sv
`timescale 1ns/10ps
// operand banks A and B plus result bank C; every read has one cycle of latency
module sram_banks (
    input  logic                            s00_axis_aclk,
    input  logic                            s00_axis_aresetn,
    input  logic                            wr_en_i,
    input  logic [npu_cfg_pkg::BANK_W-1:0]  wr_bank_i,
    input  logic [npu_cfg_pkg::ADDR_W-1:0]  wr_addr_i,
    input  logic [npu_cfg_pkg::DATA_W-1:0]  wr_data_i,
    input  logic                            rd_en_i,
    input  logic [npu_cfg_pkg::ADDR_W-1:0]  rd_addr_i,
    input  logic                            res_valid_i,
    input  logic [npu_cfg_pkg::ADDR_W-1:0]  res_addr_i,
    input  logic [npu_cfg_pkg::DATA_W-1:0]  res_data_i,
    input  logic                            out_rd_en_i,
    input  logic [npu_cfg_pkg::ADDR_W-1:0]  out_rd_addr_i,
    output logic [npu_cfg_pkg::DATA_W-1:0]  a_data_o,
    output logic [npu_cfg_pkg::DATA_W-1:0]  b_data_o,
    output logic                            rd_valid_o,
    output logic [npu_cfg_pkg::ADDR_W-1:0]  rd_addr_o,
    output logic [npu_cfg_pkg::DATA_W-1:0]  out_data_o
);
    import npu_cfg_pkg::*;

    logic [DATA_W-1:0] mem [NUM_BANKS][WORDS];

    always_ff @(posedge s00_axis_aclk) begin
        // load port reaches any bank while ALU results go to bank C
        if (wr_en_i)
            mem[wr_bank_i][wr_addr_i] <= wr_data_i;
        if (res_valid_i)
            mem[BANK_C][res_addr_i] <= res_data_i;

        // A and B read together for the ALU
        if (rd_en_i) begin
            a_data_o <= mem[BANK_A][rd_addr_i];
            b_data_o <= mem[BANK_B][rd_addr_i];
        end
        if (out_rd_en_i)
            out_data_o <= mem[BANK_C][out_rd_addr_i];

        // address follows the data so the result can be tagged
        rd_addr_o <= rd_addr_i;
    end

    always_ff @(posedge s00_axis_aclk or negedge s00_axis_aresetn) begin
        if (!s00_axis_aresetn)
            rd_valid_o <= 1'b0;
        else
            rd_valid_o <= rd_en_i;
    end

    // loading and computing never overlap
    a_one_writer: assert property (@(posedge s00_axis_aclk) disable iff (!s00_axis_aresetn)
        !(wr_en_i && res_valid_i));

endmodule

//--- hdl/stream_loader.sv
`timescale 1ns/10ps
// input AXI-stream side; turns accepted beats into bank writes addressed by tuser
module stream_loader (
    input  logic                            s00_axis_aclk,
    input  logic                            s00_axis_aresetn,
    input  logic                            load_en_i,
    input  logic [npu_cfg_pkg::DATA_W-1:0]  tdata_i,
    input  logic                            tvalid_i,
    input  logic [npu_cfg_pkg::USER_W-1:0]  tuser_i,
    output logic                            tready_o,
    output logic                            wr_en_o,
    output logic [npu_cfg_pkg::BANK_W-1:0]  wr_bank_o,
    output logic [npu_cfg_pkg::ADDR_W-1:0]  wr_addr_o,
    output logic [npu_cfg_pkg::DATA_W-1:0]  wr_data_o
);
    import npu_cfg_pkg::*;

    assign tready_o = load_en_i;

    // bank in the upper tuser bits and word address below
    assign wr_bank_o = tuser_i[USER_W-1 -: BANK_W];
    assign wr_addr_o = tuser_i[ADDR_W-1:0];
    assign wr_data_o = tdata_i;

    // write on the handshake edge and drop an unused bank number
    assign wr_en_o = tvalid_i && tready_o &&
                     (wr_bank_o inside {BANK_A, BANK_B, BANK_C});

    // a stalled beat must wait unchanged for tready
    a_hold_beat: assert property (@(posedge s00_axis_aclk) disable iff (!s00_axis_aresetn)
        tvalid_i && !tready_o |=> tvalid_i && $stable(tuser_i) && $stable(tdata_i));

endmodule

//--- hdl/stream_writer.sv
`timescale 1ns/10ps
// output AXI-stream side; reads bank C word by word and holds each beat until accepted
module stream_writer (
    input  logic                            s00_axis_aclk,
    input  logic                            s00_axis_aresetn,
    input  logic                            out_start_i,
    input  logic [npu_cfg_pkg::COUNT_W-1:0] out_words_i,
    input  logic                            tready_i,
    input  logic [npu_cfg_pkg::DATA_W-1:0]  out_data_i,
    output logic                            out_rd_en_o,
    output logic [npu_cfg_pkg::ADDR_W-1:0]  out_rd_addr_o,
    output logic [npu_cfg_pkg::DATA_W-1:0]  tdata_o,
    output logic                            tvalid_o,
    output logic                            tlast_o,
    output logic                            out_done_o
);
    import npu_cfg_pkg::*;

    logic               active_q;
    logic               rd_pend_q;
    logic [COUNT_W-1:0] words_q;
    logic [COUNT_W-1:0] ptr_q;
    logic               beat_fire;

    assign beat_fire  = tvalid_o && tready_i;
    assign out_done_o = beat_fire && tlast_o;

    // keep one word in flight and read the next once the output register frees up
    assign out_rd_en_o   = active_q && !rd_pend_q && (ptr_q < words_q) &&
                           (!tvalid_o || tready_i);
    assign out_rd_addr_o = ptr_q[ADDR_W-1:0];

    always_ff @(posedge s00_axis_aclk or negedge s00_axis_aresetn) begin
        if (!s00_axis_aresetn) begin
            active_q  <= 1'b0;
            rd_pend_q <= 1'b0;
            words_q   <= '0;
            ptr_q     <= '0;
            tvalid_o  <= 1'b0;
            tlast_o   <= 1'b0;
        end else begin
            rd_pend_q <= out_rd_en_o;
            if (out_start_i) begin
                active_q <= 1'b1;
                words_q  <= out_words_i;
                ptr_q    <= '0;
            end else if (out_rd_en_o) begin
                ptr_q <= ptr_q + COUNT_W'(1);
            end
            if (out_done_o)
                active_q <= 1'b0;
            // ptr already points past the word now arriving
            if (rd_pend_q) begin
                tvalid_o <= 1'b1;
                tlast_o  <= (ptr_q == words_q);
            end else if (beat_fire) begin
                tvalid_o <= 1'b0;
                tlast_o  <= 1'b0;
            end
        end
    end

    always_ff @(posedge s00_axis_aclk) begin
        if (rd_pend_q)
            tdata_o <= out_data_i;
    end

    a_hold_out: assert property (@(posedge s00_axis_aclk) disable iff (!s00_axis_aresetn)
        tvalid_o && !tready_i |=> tvalid_o && $stable(tdata_o) && $stable(tlast_o));

endmodule

//--- run.sh
#!/bin/sh
# builds the NPU testbench with Verilator and runs it; exit status gives the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_npu \
    -f all.f \
    -o tb_npu

./obj_dir/tb_npu

//--- test/tb_npu.sv
// testbench for npu_top; runs a table of element-wise operations through load, compute and output
`timescale 1ns/10ps
module tb_npu;
    import npu_cfg_pkg::*;
    import npu_op_pkg::*;

    localparam int SEED  = 69717;
    localparam int NUM_T = 6;

    // op, shift, words, extreme bytes, back-pressure, operations before output
    localparam op_e T_OP    [NUM_T] = '{ADD_OP, SUB_OP, ADD_OP, MUL_OP, MUL_OP, MUL_OP};
    localparam int  T_SHIFT [NUM_T] = '{0, 0, 0, 0, 3, 7};
    localparam int  T_WORDS [NUM_T] = '{12, 10, 9, 8, 16, 20};
    localparam bit  T_EXTR  [NUM_T] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
    localparam bit  T_BP    [NUM_T] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1};
    localparam int  T_RUNS  [NUM_T] = '{2, 1, 1, 1, 2, 1};

    logic               clk         = 1'b0;
    logic               aresetn     = 1'b0;
    logic [DATA_W-1:0]  s_tdata     = '0;
    logic               s_tvalid    = 1'b0;
    logic [USER_W-1:0]  s_tuser     = '0;
    logic               s_tready;
    logic [DATA_W-1:0]  m_tdata;
    logic               m_tvalid;
    logic               m_tlast;
    logic               m_tready    = 1'b0;
    op_e                op          = IDLE_OP;
    logic [SHIFT_W-1:0] mul_shift   = '0;
    logic [COUNT_W-1:0] op_words    = '0;
    logic [COUNT_W-1:0] out_words   = '0;
    logic               meta_valid  = 1'b0;
    logic               meta_done   = 1'b0;
    logic               finish_calc = 1'b0;
    logic               layer_done;

    int         cycle       = 0;
    int         limit       = 0;
    int         done_pulses = 0;
    lane_word_u mem_a [WORDS];
    lane_word_u mem_b [WORDS];
    lane_word_u exp_c [WORDS];

    npu_top i_dut (
        .s00_axis_aclk(clk), .s00_axis_aresetn(aresetn),
        .s00_axis_tdata_i(s_tdata), .s00_axis_tvalid_i(s_tvalid), .s00_axis_tuser_i(s_tuser),
        .s00_axis_tready_o(s_tready),
        .m00_axis_tdata_o(m_tdata), .m00_axis_tvalid_o(m_tvalid), .m00_axis_tlast_o(m_tlast),
        .m00_axis_tready_i(m_tready),
        .op_i(op), .mul_shift_i(mul_shift), .op_words_i(op_words), .out_words_i(out_words),
        .metadata_valid_i(meta_valid), .metadata_done_i(meta_done),
        .finish_calc_i(finish_calc), .layer_done_o(layer_done)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // watchdog over the whole run
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > limit)
            abort_run($sformatf("timeout: run still busy after %0d cycles", cycle));
    end

    always @(negedge clk) begin
        if (layer_done)
            done_pulses <= done_pulses + 1;
    end

    task automatic check_word(input string name, input lane_word_u got, input lane_word_u exp);
        if (got !== exp)
            abort_run($sformatf("FAILED %s: got %h, expected %h", name, got.raw, exp.raw));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    // int8 lane rule with saturation to -128..127
    function automatic lane_t ref_lane(input op_e o, input int shift, input int a, input int b);
        int r;
        case (o)
            ADD_OP:  r = a + b;
            SUB_OP:  r = a - b;
            default: r = (a * b) >>> shift;
        endcase
        if (r > 127)
            r = 127;
        if (r < -128)
            r = -128;
        return r[7:0];
    endfunction

    function automatic lane_word_u make_operand(input bit extreme);
        lane_word_u w;
        w.raw = {$urandom, $urandom};
        if (extreme) begin
            for (int l = 0; l < LANES; l++)
                w.lane[l] = ($urandom_range(0, 1) != 0) ? 8'sh7f : 8'sh80;
        end
        return w;
    endfunction

    task automatic send_beat(input logic [BANK_W-1:0] bank, input int addr,
                             input logic [DATA_W-1:0] data);
        check_bit("s00_axis_tready_o", s_tready, 1'b1);
        s_tvalid = 1'b1;
        s_tuser  = {bank, ADDR_W'(addr)};
        s_tdata  = data;
        @(negedge clk);
    endtask

    // ------------------------------------------------------------------------
    // load, compute and output phases
    // ------------------------------------------------------------------------
    task automatic load_banks(input int n, input bit extreme);
        for (int i = 0; i < n; i++) begin
            mem_a[i] = make_operand(extreme);
            mem_b[i] = make_operand(extreme);
            send_beat(BANK_A, i, mem_a[i].raw);
            send_beat(BANK_B, i, mem_b[i].raw);
        end
        // bank 3 does not exist and must be dropped
        send_beat(2'd3, 0, {$urandom, $urandom});
        s_tvalid = 1'b0;
    endtask

    task automatic run_op(input op_e o, input int shift, input int n);
        int t0;
        for (int i = 0; i < n; i++) begin
            for (int l = 0; l < LANES; l++)
                exp_c[i].lane[l] = ref_lane(o, shift, mem_a[i].lane[l], mem_b[i].lane[l]);
        end
        op        = o;
        mul_shift = SHIFT_W'(shift);
        op_words  = COUNT_W'(n);
        meta_done = 1'b1;
        @(negedge clk);
        meta_done = 1'b0;
        // edge that sampled metadata_done
        t0 = cycle;
        do begin
            @(negedge clk);
            check_bit("layer_done_o", layer_done, cycle == t0 + n + 3);
            if (!layer_done)
                check_bit("s00_axis_tready_o", s_tready, 1'b0);
        end while (!layer_done);
        @(negedge clk);
        check_bit("layer_done_o", layer_done, 1'b0);
        check_bit("s00_axis_tready_o", s_tready, 1'b1);
    endtask

    task automatic collect_output(input int n, input bit bp);
        int   idx;
        logic ready;
        idx         = 0;
        finish_calc = 1'b1;
        out_words   = COUNT_W'(n);
        @(negedge clk);
        finish_calc = 1'b0;
        while (idx < n) begin
            check_bit("s00_axis_tready_o", s_tready, 1'b0);
            ready    = bp ? ($urandom_range(0, 2) != 0) : 1'b1;
            m_tready = ready;
            // outputs are stable here until the next rising edge
            if (m_tvalid) begin
                // a stalled beat keeps its word and tlast until accepted
                check_word("m00_axis_tdata_o", m_tdata, exp_c[idx]);
                check_bit("m00_axis_tlast_o", m_tlast, idx == n - 1);
                if (ready)
                    idx++;
            end
            @(negedge clk);
        end
        m_tready = 1'b0;
        check_bit("m00_axis_tvalid_o", m_tvalid, 1'b0);
    endtask

    initial begin
        int seed_val;
        int total_runs;
        seed_val   = $urandom(SEED);
        total_runs = 0;
        // limit grows with the words of each entry
        for (int t = 0; t < NUM_T; t++) begin
            limit      += 4 * T_WORDS[t] + 200;
            total_runs += T_RUNS[t];
        end
        repeat (16) @(negedge clk);
        aresetn = 1'b1;
        @(negedge clk);
        check_bit("s00_axis_tready_o", s_tready, 1'b0);
        check_bit("m00_axis_tvalid_o", m_tvalid, 1'b0);
        check_bit("m00_axis_tlast_o", m_tlast, 1'b0);
        check_bit("layer_done_o", layer_done, 1'b0);

        for (int t = 0; t < NUM_T; t++) begin
            meta_valid = 1'b1;
            @(negedge clk);
            meta_valid = 1'b0;
            // later runs start straight from WAIT_META
            for (int r = 0; r < T_RUNS[t]; r++) begin
                load_banks(T_WORDS[t], T_EXTR[t]);
                run_op(T_OP[t], T_SHIFT[t], T_WORDS[t]);
            end
            collect_output(T_WORDS[t], T_BP[t]);
        end

        if (done_pulses != total_runs) begin
            abort_run($sformatf("layer_done_o pulsed %0d times for %0d operations",
                                done_pulses, total_runs));
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule
